// ==== common/awg_delay_pkg.sv ====
package awg_delay_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // subsystem widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int NUM_CH    = 4;   // default dac channel count of the top level
  parameter int WAVE_ID_W = 11;  // 2048 waveforms per channel
  parameter int DELAY_W   = 24;  // trigger delay in clock cycles
  parameter int CH_IDX_W  = 2;   // enough for NUM_CH channels

  ////////////////////////////////////////////////////////////////////////////
  // payload types
  ////////////////////////////////////////////////////////////////////////////

  // table address
  typedef logic [WAVE_ID_W-1:0] wave_id_t;

  // one stored delay and the countdown value
  typedef logic [DELAY_W-1:0] delay_t;

  // channel select on host commands and credit returns
  typedef logic [CH_IDX_W-1:0] ch_idx_t;

endpackage

// ==== src/awg_cmd_dispatch.sv ====
module awg_cmd_dispatch #(
  parameter int NUM_CH = awg_delay_pkg::NUM_CH
) (
  input  logic                   I_UART_CLK,
  input  logic                   I_Rst_n,

  // host table write
  input  logic                   wr_valid,
  input  awg_delay_pkg::ch_idx_t wr_ch,
  input  awg_delay_pkg::wave_id_t wr_wave_id,
  input  awg_delay_pkg::delay_t  wr_delay,

  // host play request
  input  logic                   play_valid,
  input  awg_delay_pkg::ch_idx_t play_ch,
  input  awg_delay_pkg::wave_id_t play_wave_id,

  // one-hot enables and shared buses to the channels
  output logic [NUM_CH-1:0]      ch_wr_en,
  output awg_delay_pkg::wave_id_t ch_wr_wave_id,
  output awg_delay_pkg::delay_t  ch_wr_delay,
  output logic [NUM_CH-1:0]      ch_play_en,
  output awg_delay_pkg::wave_id_t ch_play_wave_id
);

  // shared id and data buses registered once for all channels
  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) begin
      ch_wr_wave_id   <= '0;
      ch_wr_delay     <= '0;
      ch_play_wave_id <= '0;
    end else begin
      ch_wr_wave_id   <= wr_wave_id;
      ch_wr_delay     <= wr_delay;
      ch_play_wave_id <= play_wave_id;
    end
  end

  // channel index decoded to a one-hot enable one cycle after the host edge
  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) begin
      ch_wr_en   <= '0;
      ch_play_en <= '0;
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        ch_wr_en[i]   <= wr_valid && (wr_ch == i);     // write needs no credit
        ch_play_en[i] <= play_valid && (play_ch == i); // credit spent by host
      end
    end
  end

endmodule

// ==== delay_channel/delay_table_ram.sv ====
module delay_table_ram (
  input  logic                    I_UART_CLK,
  input  logic                    I_Rst_n,

  // write port fed from the dispatcher registers
  input  logic                    wr_en,
  input  awg_delay_pkg::wave_id_t wr_wave_id,
  input  awg_delay_pkg::delay_t   wr_delay,

  // read port with one cycle of latency
  input  logic                    rd_en,
  input  awg_delay_pkg::wave_id_t rd_wave_id,
  output awg_delay_pkg::delay_t   rd_delay,
  output logic                    rd_valid
);

  import awg_delay_pkg::*;

  delay_t mem [2**WAVE_ID_W];  // one delay per waveform id

  always_ff @(posedge I_UART_CLK) begin
    if (wr_en) mem[wr_wave_id] <= wr_delay;
    if (rd_en) rd_delay <= mem[rd_wave_id];  // read before write on same id
  end

  // marks the cycle rd_delay holds a fresh lookup
  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) rd_valid <= 1'b0;
    else          rd_valid <= rd_en;
  end

endmodule

// ==== delay_channel/delay_channel.sv ====
module delay_channel #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    I_UART_CLK,
  input  logic                    I_Rst_n,

  // table write from dispatcher
  input  logic                    wr_en,
  input  awg_delay_pkg::wave_id_t wr_wave_id,
  input  awg_delay_pkg::delay_t   wr_delay,

  // play request from dispatcher
  input  logic                    play_en,
  input  awg_delay_pkg::wave_id_t play_wave_id,

  output logic                    trig,       // one-cycle pulse per request
  output logic                    credit_evt  // one pulse per pop
);

  import awg_delay_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  delay_t             rd_delay;
  logic               rd_valid;
  delay_t             queue [FIFO_DEPTH];  // pending delays in arrival order
  logic [PTR_W-1:0]   wr_ptr, rd_ptr;
  logic [CNT_W-1:0]   q_cnt;
  logic               q_empty;
  delay_t             cnt;                 // countdown
  logic               busy;
  logic               expire;
  logic               pop;

  delay_table_ram u_table (
    .I_UART_CLK (I_UART_CLK),
    .I_Rst_n    (I_Rst_n),
    .wr_en      (wr_en),
    .wr_wave_id (wr_wave_id),
    .wr_delay   (wr_delay),
    .rd_en      (play_en),       // every play is a lookup
    .rd_wave_id (play_wave_id),
    .rd_delay   (rd_delay),
    .rd_valid   (rd_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pending-delay queue
  ////////////////////////////////////////////////////////////////////////////

  assign q_empty = (q_cnt == '0);
  assign expire  = busy && (cnt == '0);          // fires trig at this edge
  assign pop     = !q_empty && (!busy || expire); // reload back to back
  assign credit_evt = pop;

  always_ff @(posedge I_UART_CLK) begin
    if (rd_valid) queue[wr_ptr] <= rd_delay;
  end

  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (rd_valid) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)      rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      q_cnt <= q_cnt + CNT_W'(rd_valid) - CNT_W'(pop);  // overflow ruled out by credits
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // countdown and trigger
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      trig <= 1'b0;
    end else begin
      trig <= expire;               // D+1 edges after the pop edge
      if (pop) begin
        cnt  <= queue[rd_ptr];
        busy <= 1'b1;
      end else if (expire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

// ==== src/credit_return_merge.sv ====
module credit_return_merge #(
  parameter int NUM_CH     = awg_delay_pkg::NUM_CH,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   I_UART_CLK,
  input  logic                   I_Rst_n,
  input  logic [NUM_CH-1:0]      credit_evt,   // pop pulses from channels
  output logic                   credit_valid,
  output awg_delay_pkg::ch_idx_t credit_ch
);

  import awg_delay_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CNT_W-1:0]  pend [NUM_CH];  // credits waiting per channel
  logic [NUM_CH-1:0] has_pend;
  logic              grant_any;
  ch_idx_t           grant_ch;
  ch_idx_t           last_ch;        // round-robin pointer

  // an event counts in its own cycle
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) has_pend[i] = (pend[i] != '0) || credit_evt[i];
  end

  // nearest pending channel after last_ch wins
  always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_ch  = '0;
    for (int k = NUM_CH; k >= 1; k--) begin
      idx = (int'(last_ch) + k) % NUM_CH;
      if (has_pend[idx]) begin
        grant_any = 1'b1;
        grant_ch  = ch_idx_t'(idx);
      end
    end
  end

  always_ff @(posedge I_UART_CLK or negedge I_Rst_n) begin
    if (!I_Rst_n) begin
      for (int i = 0; i < NUM_CH; i++) pend[i] <= '0;
      last_ch      <= '0;
      credit_valid <= 1'b0;
      credit_ch    <= '0;
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        // event and grant on one channel cancel
        pend[i] <= pend[i] + CNT_W'(credit_evt[i]) - CNT_W'(grant_any && (grant_ch == i));
      end
      if (grant_any) last_ch <= grant_ch;
      credit_valid <= grant_any;
      credit_ch    <= grant_ch;
    end
  end

endmodule

// ==== src/awg_delay_top.sv ====
module awg_delay_top #(
  parameter int NUM_CH     = awg_delay_pkg::NUM_CH,
  parameter int FIFO_DEPTH = 4   // queue depth and initial host credits
) (
  input  logic                    I_UART_CLK,
  input  logic                    I_Rst_n,

  input  logic                    wr_valid,
  input  awg_delay_pkg::ch_idx_t  wr_ch,
  input  awg_delay_pkg::wave_id_t wr_wave_id,
  input  awg_delay_pkg::delay_t   wr_delay,

  input  logic                    play_valid,
  input  awg_delay_pkg::ch_idx_t  play_ch,
  input  awg_delay_pkg::wave_id_t play_wave_id,

  output logic [NUM_CH-1:0]       trig,
  output logic                    credit_valid,
  output awg_delay_pkg::ch_idx_t  credit_ch
);

  import awg_delay_pkg::*;

  logic [NUM_CH-1:0] ch_wr_en, ch_play_en;
  wave_id_t          ch_wr_wave_id, ch_play_wave_id;
  delay_t            ch_wr_delay;
  logic [NUM_CH-1:0] credit_evt;

  awg_cmd_dispatch #(.NUM_CH(NUM_CH)) u_dispatch (
    .I_UART_CLK      (I_UART_CLK),
    .I_Rst_n         (I_Rst_n),
    .wr_valid        (wr_valid),
    .wr_ch           (wr_ch),
    .wr_wave_id      (wr_wave_id),
    .wr_delay        (wr_delay),
    .play_valid      (play_valid),
    .play_ch         (play_ch),
    .play_wave_id    (play_wave_id),
    .ch_wr_en        (ch_wr_en),
    .ch_wr_wave_id   (ch_wr_wave_id),
    .ch_wr_delay     (ch_wr_delay),
    .ch_play_en      (ch_play_en),
    .ch_play_wave_id (ch_play_wave_id)
  );

  // one table, queue and counter per dac channel
  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    delay_channel #(.FIFO_DEPTH(FIFO_DEPTH)) u_ch (
      .I_UART_CLK   (I_UART_CLK),
      .I_Rst_n      (I_Rst_n),
      .wr_en        (ch_wr_en[g]),
      .wr_wave_id   (ch_wr_wave_id),
      .wr_delay     (ch_wr_delay),
      .play_en      (ch_play_en[g]),
      .play_wave_id (ch_play_wave_id),
      .trig         (trig[g]),
      .credit_evt   (credit_evt[g])
    );
  end

  credit_return_merge #(.NUM_CH(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) u_merge (
    .I_UART_CLK   (I_UART_CLK),
    .I_Rst_n      (I_Rst_n),
    .credit_evt   (credit_evt),
    .credit_valid (credit_valid),
    .credit_ch    (credit_ch)
  );

endmodule

// ==== testbench/tb_awg_delay.sv ====
module tb_awg_delay;

  timeunit 1ns;
  timeprecision 100ps;

  import awg_delay_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int TMO        = 100000;  // cycles allowed per wait
  localparam int LOG_MAX    = 64;      // trig slots per channel and test

  logic              I_UART_CLK;
  logic              I_Rst_n;
  logic              wr_valid, play_valid;
  ch_idx_t           wr_ch, play_ch;
  wave_id_t          wr_wave_id, play_wave_id;
  delay_t            wr_delay;
  logic [NUM_CH-1:0] trig;
  logic              credit_valid;
  ch_idx_t           credit_ch;

  int cyc = 0;                          // posedges so far
  int errors = 0;
  int checks = 0;
  int credits [NUM_CH];                 // host side credit count
  int credit_cnt [NUM_CH];              // credits seen over the run
  int play_cnt [NUM_CH];
  int last_trig [NUM_CH];               // predicted edge of the newest trig
  int trig_edge [NUM_CH][LOG_MAX];
  int trig_n [NUM_CH];
  int exp_edge [NUM_CH][LOG_MAX];
  int exp_n [NUM_CH];

  awg_delay_top #(.NUM_CH(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
    .I_UART_CLK   (I_UART_CLK),
    .I_Rst_n      (I_Rst_n),
    .wr_valid     (wr_valid),
    .wr_ch        (wr_ch),
    .wr_wave_id   (wr_wave_id),
    .wr_delay     (wr_delay),
    .play_valid   (play_valid),
    .play_ch      (play_ch),
    .play_wave_id (play_wave_id),
    .trig         (trig),
    .credit_valid (credit_valid),
    .credit_ch    (credit_ch)
  );

  initial begin
    I_UART_CLK = 1'b0;
    forever #50 I_UART_CLK = ~I_UART_CLK;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // monitor of the values launched by the previous edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge I_UART_CLK) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (trig[i] && trig_n[i] < LOG_MAX) begin
        trig_edge[i][trig_n[i]] = cyc;   // edge that raised the pulse
        trig_n[i]++;
      end
    end
    if (credit_valid) begin
      credits[credit_ch]++;
      credit_cnt[credit_ch]++;
      if (credits[credit_ch] > FIFO_DEPTH) begin
        $display("channel %0d returned more credits than it was given", credit_ch);
        errors++;
      end
    end
    cyc++;
  end

  // 16-bit galois lfsr stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input longint expected, input longint actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // waits for every predicted trig and credit before comparing
  task automatic end_test(input string name);
    int e0;
    int tmo;
    e0 = errors;
    for (int c = 0; c < NUM_CH; c++) begin
      tmo = 0;
      while (trig_n[c] < exp_n[c] && tmo < TMO) begin
        @(negedge I_UART_CLK);
        tmo++;
      end
      if (trig_n[c] < exp_n[c]) begin
        $display("no trigger came on channel %0d in test %s", c, name);
        errors++;
      end
      tmo = 0;
      while (credits[c] != FIFO_DEPTH && tmo < TMO) begin
        @(negedge I_UART_CLK);
        tmo++;
      end
      if (credits[c] != FIFO_DEPTH) begin
        $display("credits of channel %0d did not come back in test %s", c, name);
        errors++;
      end
    end
    repeat (8) @(negedge I_UART_CLK);  // room for stray pulses
    for (int c = 0; c < NUM_CH; c++) begin
      check_value($sformatf("%s ch%0d trig count", name, c), exp_n[c], trig_n[c]);
      for (int k = 0; k < exp_n[c] && k < trig_n[c]; k++)
        check_value($sformatf("%s ch%0d trig %0d edge", name, c, k),
                    exp_edge[c][k], trig_edge[c][k]);
      exp_n[c]  = 0;
      trig_n[c] = 0;
    end
    $display("test %-22s %s, %0d errors", name, (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus from the golden file
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int n;
    int ch, id, dly, req, exp_t, tmo;
    int tests;
    int e0;
    bit abort;
    string op, name;
    logic [8*128-1:0] line;
    logic [15:0] lfsr;
    logic [2:0] gap;

    tests = 0;
    abort = 1'b0;
    lfsr  = 16'd26;
    I_Rst_n = 1'b0;
    wr_valid = 1'b0;
    play_valid = 1'b0;
    wr_ch = '0;
    play_ch = '0;
    wr_wave_id = '0;
    play_wave_id = '0;
    wr_delay = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      credits[c] = FIFO_DEPTH;
      credit_cnt[c] = 0;
      play_cnt[c] = 0;
      last_trig[c] = 0;
      trig_n[c] = 0;
      exp_n[c] = 0;
    end
    repeat (8) @(negedge I_UART_CLK);
    I_Rst_n = 1'b1;

    fd = $fopen("testbench/golden_delay_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden vector file");
      errors++;
      abort = 1'b1;
    end

    while (!abort && $fscanf(fd, "%s", op) == 1) begin
      if (op == "W") begin
        n = $fscanf(fd, "%d %d %d", ch, id, dly);
        if (n != 3) begin
          $display("a write line in the golden vector file is incomplete");
          errors++;
          abort = 1'b1;
        end else begin
          wr_ch = ch_idx_t'(ch);
          wr_wave_id = wave_id_t'(id);
          wr_delay = delay_t'(dly);
          wr_valid = 1'b1;
          @(negedge I_UART_CLK);
          wr_valid = 1'b0;
        end
      end else if (op == "P") begin
        n = $fscanf(fd, "%d %d %d", ch, id, dly);
        if (n != 3) begin
          $display("a play line in the golden vector file is incomplete");
          errors++;
          abort = 1'b1;
        end else begin
          for (int b = 0; b < 3; b++) begin
            gap  = {gap[1:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
          end
          repeat (gap) @(negedge I_UART_CLK);
          tmo = 0;
          while (credits[ch] == 0 && tmo < TMO) begin  // stall for a credit
            @(negedge I_UART_CLK);
            tmo++;
          end
          if (credits[ch] == 0) begin
            $display("no credit came back for channel %0d", ch);
            errors++;
            abort = 1'b1;
          end else begin
            req   = cyc + 1;                 // edge that samples the request
            exp_t = req + 4 + dly;           // idle channel
            if (last_trig[ch] + dly + 1 > exp_t) exp_t = last_trig[ch] + dly + 1;  // queued
            last_trig[ch] = exp_t;
            exp_edge[ch][exp_n[ch]] = exp_t;
            exp_n[ch]++;
            credits[ch]--;
            play_cnt[ch]++;
            play_ch = ch_idx_t'(ch);
            play_wave_id = wave_id_t'(id);
            play_valid = 1'b1;
            @(negedge I_UART_CLK);
            play_valid = 1'b0;
          end
        end
      end else if (op == "E") begin
        n = $fscanf(fd, "%s", name);
        end_test(name);
        tests++;
      end else begin
        n = $fgets(line, fd);   // comment line
      end
    end
    if (fd != 0) $fclose(fd);

    // whole-run credit balance
    if (!abort) begin
      e0 = errors;
      repeat (20) @(negedge I_UART_CLK);
      for (int c = 0; c < NUM_CH; c++) begin
        check_value($sformatf("credits returned ch%0d", c), play_cnt[c], credit_cnt[c]);
        check_value($sformatf("credits held ch%0d", c), FIFO_DEPTH, credits[c]);
        check_value($sformatf("pending trig ch%0d", c), exp_n[c], trig_n[c]);
      end
      tests++;
      $display("test %-22s %s, %0d errors", "credit_conservation",
               (errors == e0) ? "ok" : "failed", errors - e0);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== testbench/golden_delay_vectors.txt ====
# W ch wave_id delay   table write
# P ch wave_id expected_delay   play request, E test_name closes a test
W 0 5 10
W 1 100 3
W 2 100 25
W 3 2047 6
P 0 5 10
P 1 100 3
P 2 100 25
P 3 2047 6
E single_lookup
W 0 0 0
W 1 1 66051
P 0 0 0
P 1 1 66051
E wide_delays
W 3 12 40
W 3 13 0
P 3 12 40
P 3 13 0
P 3 12 40
P 3 13 0
P 3 12 40
E queued_requests
P 0 5 10
P 1 100 3
P 2 100 25
P 3 2047 6
W 2 100 5
P 2 100 5
P 1 100 3
E channel_independence

// ==== tb.f ====
common/awg_delay_pkg.sv
src/awg_cmd_dispatch.sv
delay_channel/delay_table_ram.sv
delay_channel/delay_channel.sv
src/credit_return_merge.sv
src/awg_delay_top.sv
testbench/tb_awg_delay.sv

// ==== Bender.yml ====
package:
  name: awg_delay

sources:
  - files:
      - common/awg_delay_pkg.sv
      - src/awg_cmd_dispatch.sv
      - delay_channel/delay_table_ram.sv
      - delay_channel/delay_channel.sv
      - src/credit_return_merge.sv
      - src/awg_delay_top.sv
  - target: test
    files:
      - testbench/tb_awg_delay.sv

export_include_dirs: []

vendor_package: []

workspace: {}

frozen: false
